// File: Bender.yml
package:
  name: mbox

sources:
  # mailbox RTL in compile order
  - files:
      - hdl/mbox_pkg.sv
      - hdl/mbox_mem_if.sv
      - hdl/mbox_boot_fsm.sv
      - hdl/mbox_fuse_regs.sv
      - hdl/mbox_mem_arbiter.sv
      - hdl/mbox_sram.sv
      - hdl/mbox_top.sv

  # testbench, top module mbox_tb
  - target: simulation
    files:
      - verif/mbox_tb.sv

// File: hdl/mbox_boot_fsm.sv
// **********************************************************************
// uC reset is released only from BOOT_DONE, two cycles after entering it
// **********************************************************************
`default_nettype none

module mbox_boot_fsm (
    input  logic clk,
    input  logic arst_n,
    input  logic pwrgood,
    input  logic fuse_done,
    output logic ready_for_fuses,
    output logic uc_rst_b
);
    import mbox_pkg::*;

    boot_state_e state_q;
    boot_state_e state_d;

    // transition conditions out of idle and fuse
    logic arc_idle_fuse;
    logic arc_fuse_done;

    // enable for the first stage of the uC reset release
    logic release_en;
    logic release_q;

    // leave idle once power is good and we are out of reset
    assign arc_idle_fuse = pwrgood && arst_n;

    // the sticky done flag from the fuse bank closes the fuse phase
    assign arc_fuse_done = fuse_done;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            BOOT_IDLE: begin
                if (arc_idle_fuse) begin
                    state_d = BOOT_FUSE;
                end
            end
            BOOT_FUSE: begin
                if (arc_fuse_done) begin
                    state_d = BOOT_DONE;
                end
            end
            BOOT_DONE: begin
                // terminal until the next reset
                state_d = BOOT_DONE;
            end
            default: begin
                // the unused encoding falls back to idle
                state_d = BOOT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= BOOT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // fuse writes are accepted only while the bank is open
    assign ready_for_fuses = (state_q == BOOT_FUSE);

    // the release stage only loads a one in BOOT_DONE
    assign release_en = (state_q == BOOT_DONE);

    // two flops between the state and the uC reset pin
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            release_q <= 1'b0;
            uc_rst_b  <= 1'b0;
        end else begin
            if (release_en) begin
                release_q <= 1'b1;
            end
            uc_rst_b <= release_q;
        end
    end

endmodule : mbox_boot_fsm

`default_nettype wire

// File: hdl/mbox_fuse_regs.sv
// **********************************************************************
// SoC writes outside the fuse phase are dropped without any response
// **********************************************************************
`default_nettype none

module mbox_fuse_regs (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 ready_for_fuses,
    input  logic                 fuse_wr,
    input  mbox_pkg::fuse_addr_t fuse_addr,
    input  mbox_pkg::mbox_data_t fuse_wdata,
    input  mbox_pkg::fuse_addr_t uc_fuse_addr,
    output mbox_pkg::mbox_data_t uc_fuse_rdata,
    output logic                 fuse_done
);
    import mbox_pkg::*;

    mbox_data_t fuse_q [FUSE_WORDS];

    // a write only counts while the sequencer has the bank open
    logic wr_ok;
    // the write targets one of the stored words
    logic wr_word;
    // the write is the fuse-done command
    logic wr_done;
    // the uC read address falls inside the word range
    logic rd_word;

    assign wr_ok   = fuse_wr && ready_for_fuses;
    assign wr_word = wr_ok && (fuse_addr < fuse_addr_t'(FUSE_WORDS));
    assign wr_done = wr_ok && (fuse_addr == FUSE_DONE_ADDR);

    // the fuse words come up as zero until the SoC loads them
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < FUSE_WORDS; i++) begin
                fuse_q[i] <= '0;
            end
        end else if (wr_word) begin
            fuse_q[fuse_addr[FUSE_IDX_W-1:0]] <= fuse_wdata;
        end
    end

    // done is sticky, the data of the command write is ignored
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fuse_done <= 1'b0;
        end else if (wr_done) begin
            fuse_done <= 1'b1;
        end
    end

    assign rd_word = (uc_fuse_addr < fuse_addr_t'(FUSE_WORDS));

    // uC reads are combinational and always allowed
    // the command slot and anything above it read as zero
    always_comb begin
        if (rd_word) begin
            uc_fuse_rdata = fuse_q[uc_fuse_addr[FUSE_IDX_W-1:0]];
        end else begin
            uc_fuse_rdata = '0;
        end
    end

endmodule : mbox_fuse_regs

`default_nettype wire

// File: hdl/mbox_mem_arbiter.sv
// **********************************************************************
// round-robin between SoC and uC; uC is masked while held in reset
// **********************************************************************
`default_nettype none

module mbox_mem_arbiter (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 uc_rst_b,
    mbox_mem_if.arbiter          soc,
    mbox_mem_if.arbiter          uc,
    output logic                 mem_en,
    output logic                 mem_we,
    output mbox_pkg::mbox_addr_t mem_addr,
    output mbox_pkg::mbox_data_t mem_wdata,
    input  mbox_pkg::mbox_data_t mem_rdata
);
    import mbox_pkg::*;

    // uC request after masking by its reset
    logic uc_req;
    logic gnt_soc;
    logic gnt_uc;

    // set when the SoC won the last grant
    // cleared at reset so the SoC takes the first contest
    logic last_soc_q;

    // a read was granted last cycle, so mem_rdata belongs to that side
    logic rd_soc_q;
    logic rd_uc_q;

    // read data kept after the one cycle it is live on the SRAM
    mbox_data_t soc_hold_q;
    mbox_data_t uc_hold_q;

    // requests from a uC that is still in reset never win
    assign uc_req = uc.req && uc_rst_b;

    // a lone request wins at once, on a tie the side that lost last time wins
    assign gnt_soc = soc.req && (!uc_req || !last_soc_q);
    assign gnt_uc  = uc_req && (!soc.req || last_soc_q);

    assign soc.gnt = gnt_soc;
    assign uc.gnt  = gnt_uc;

    // steer the winner onto the single SRAM port
    assign mem_en    = gnt_soc || gnt_uc;
    assign mem_we    = gnt_uc ? uc.we    : soc.we;
    assign mem_addr  = gnt_uc ? uc.addr  : soc.addr;
    assign mem_wdata = gnt_uc ? uc.wdata : soc.wdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_soc_q <= 1'b0;
            rd_soc_q   <= 1'b0;
            rd_uc_q    <= 1'b0;
        end else begin
            if (gnt_soc) begin
                last_soc_q <= 1'b1;
            end else if (gnt_uc) begin
                last_soc_q <= 1'b0;
            end
            rd_soc_q <= gnt_soc && !soc.we;
            rd_uc_q  <= gnt_uc && !uc.we;
        end
    end

    // capture the read word so it stays put until the next read to that side
    always_ff @(posedge clk) begin
        if (rd_soc_q) begin
            soc_hold_q <= mem_rdata;
        end
        if (rd_uc_q) begin
            uc_hold_q <= mem_rdata;
        end
    end

    // in the cycle after the grant the SRAM output goes straight through
    assign soc.rdata = rd_soc_q ? mem_rdata : soc_hold_q;
    assign uc.rdata  = rd_uc_q ? mem_rdata : uc_hold_q;

endmodule : mbox_mem_arbiter

`default_nettype wire

// File: hdl/mbox_mem_if.sv
// **********************************************************************
// one requester's path to the mailbox SRAM; strobes, not ready/valid
// **********************************************************************
`default_nettype none

interface mbox_mem_if;
    import mbox_pkg::*;

    // request side, held steady by the requester until gnt is seen
    logic       req;
    logic       we;
    mbox_addr_t addr;
    mbox_data_t wdata;

    // gnt pulses for one cycle when the access reaches the SRAM
    logic       gnt;
    // read data is valid the cycle after gnt and then holds
    mbox_data_t rdata;

    // the side that issues accesses
    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    // the side that grants them and returns read data
    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface : mbox_mem_if

`default_nettype wire

// File: hdl/mbox_pkg.sv
// **********************************************************************
// shared types and sizes for the mailbox; fuse address 8 is the
// fuse-done command and is never stored as a word
// **********************************************************************
`default_nettype none

package mbox_pkg;

    // width of one mailbox or fuse word
    localparam int unsigned DATA_W = 32;

    // mailbox SRAM geometry
    localparam int unsigned MBOX_DEPTH = 64;
    localparam int unsigned MBOX_ADDR_W = $clog2(MBOX_DEPTH);

    // fuse bank geometry
    localparam int unsigned FUSE_WORDS = 8;
    localparam int unsigned FUSE_IDX_W = $clog2(FUSE_WORDS);
    // one extra address bit leaves room for the command slot above the words
    localparam int unsigned FUSE_ADDR_W = 4;

    // data and address types shared by all blocks
    typedef logic [DATA_W-1:0] mbox_data_t;
    typedef logic [MBOX_ADDR_W-1:0] mbox_addr_t;
    typedef logic [FUSE_ADDR_W-1:0] fuse_addr_t;

    // writing any data here closes the fuse phase
    localparam fuse_addr_t FUSE_DONE_ADDR = fuse_addr_t'(8);

    // boot sequencer states
    // idle waits for power-good, fuse accepts SoC fuse writes,
    // done is terminal and lets the uC out of reset
    typedef enum logic [1:0] {
        BOOT_IDLE = 2'd0,
        BOOT_FUSE = 2'd1,
        BOOT_DONE = 2'd2
    } boot_state_e;

endpackage : mbox_pkg

`default_nettype wire

// File: hdl/mbox_sram.sv
// **********************************************************************
// single port, read data one cycle after en; contents undefined at reset
// **********************************************************************
`default_nettype none

module mbox_sram (
    input  logic                 clk,
    input  logic                 en,
    input  logic                 we,
    input  mbox_pkg::mbox_addr_t addr,
    input  mbox_pkg::mbox_data_t wdata,
    output mbox_pkg::mbox_data_t rdata
);
    import mbox_pkg::*;

    mbox_data_t mem_q [MBOX_DEPTH];

    // a write leaves rdata alone, so the last read result stays visible
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem_q[addr] <= wdata;
            end else begin
                rdata <= mem_q[addr];
            end
        end
    end

endmodule : mbox_sram

`default_nettype wire

// File: hdl/mbox_top.sv
// **********************************************************************
// requesters hold req, we, addr and wdata steady until their gnt pulse
// **********************************************************************
`default_nettype none

module mbox_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 pwrgood,
    output logic                 ready_for_fuses,
    output logic                 uc_rst_b,
    // SoC fuse load port
    input  logic                 fuse_wr,
    input  mbox_pkg::fuse_addr_t fuse_addr,
    input  mbox_pkg::mbox_data_t fuse_wdata,
    // uC fuse read port
    input  mbox_pkg::fuse_addr_t uc_fuse_addr,
    output mbox_pkg::mbox_data_t uc_fuse_rdata,
    // SoC mailbox port
    input  logic                 soc_req,
    input  logic                 soc_we,
    input  mbox_pkg::mbox_addr_t soc_addr,
    input  mbox_pkg::mbox_data_t soc_wdata,
    output logic                 soc_gnt,
    output mbox_pkg::mbox_data_t soc_rdata,
    // uC mailbox port
    input  logic                 uc_req,
    input  logic                 uc_we,
    input  mbox_pkg::mbox_addr_t uc_addr,
    input  mbox_pkg::mbox_data_t uc_wdata,
    output logic                 uc_gnt,
    output mbox_pkg::mbox_data_t uc_rdata
);
    import mbox_pkg::*;

    // sticky flag from the fuse bank into the sequencer
    logic fuse_done;

    // arbiter to SRAM
    logic       mem_en;
    logic       mem_we;
    mbox_addr_t mem_addr;
    mbox_data_t mem_wdata;
    mbox_data_t mem_rdata;

    mbox_mem_if soc_if ();
    mbox_mem_if uc_if ();

    // map the flat top-level ports onto the two bundles
    assign soc_if.req   = soc_req;
    assign soc_if.we    = soc_we;
    assign soc_if.addr  = soc_addr;
    assign soc_if.wdata = soc_wdata;
    assign soc_gnt      = soc_if.gnt;
    assign soc_rdata    = soc_if.rdata;

    assign uc_if.req    = uc_req;
    assign uc_if.we     = uc_we;
    assign uc_if.addr   = uc_addr;
    assign uc_if.wdata  = uc_wdata;
    assign uc_gnt       = uc_if.gnt;
    assign uc_rdata     = uc_if.rdata;

    mbox_boot_fsm u_boot_fsm (
        .clk             (clk),
        .arst_n          (arst_n),
        .pwrgood         (pwrgood),
        .fuse_done       (fuse_done),
        .ready_for_fuses (ready_for_fuses),
        .uc_rst_b        (uc_rst_b)
    );

    mbox_fuse_regs u_fuse_regs (
        .clk             (clk),
        .arst_n          (arst_n),
        .ready_for_fuses (ready_for_fuses),
        .fuse_wr         (fuse_wr),
        .fuse_addr       (fuse_addr),
        .fuse_wdata      (fuse_wdata),
        .uc_fuse_addr    (uc_fuse_addr),
        .uc_fuse_rdata   (uc_fuse_rdata),
        .fuse_done       (fuse_done)
    );

    // uC accesses are blocked by the same reset the sequencer releases
    mbox_mem_arbiter u_arbiter (
        .clk       (clk),
        .arst_n    (arst_n),
        .uc_rst_b  (uc_rst_b),
        .soc       (soc_if.arbiter),
        .uc        (uc_if.arbiter),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    mbox_sram u_sram (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule : mbox_top

`default_nettype wire

// File: list.f
hdl/mbox_pkg.sv
hdl/mbox_mem_if.sv
hdl/mbox_boot_fsm.sv
hdl/mbox_fuse_regs.sv
hdl/mbox_mem_arbiter.sv
hdl/mbox_sram.sv
hdl/mbox_top.sv
verif/mbox_tb.sv

// File: verif/mbox_cases.txt
# columns: opcode address data expected, all numbers in hex
# CONTEND draws its data from the LFSR, so its data and expected columns are 0
UC_WR 05 0badf00d 0
FUSE_WR 0 11111111 0
FUSE_RD 0 0 0
PWRGOOD 0 0 1
FUSE_WR 0 a5a5a5a5 0
FUSE_WR 1 12345678 0
FUSE_WR 7 deadbeef 0
FUSE_RD 0 0 a5a5a5a5
FUSE_RD 1 0 12345678
FUSE_RD 7 0 deadbeef
FUSE_RD 8 0 0
SOC_WR 00 cafe0000 0
SOC_WR 3f cafe003f 0
SOC_RD 00 0 cafe0000
UC_RD 00 0 0
UC_WR 10 0000beef 0
FUSE_WR 8 0 0
FUSE_WR 1 ffffffff 0
FUSE_RD 1 0 12345678
FUSE_RD 0 0 a5a5a5a5
UC_WR 20 00c0ffee 0
UC_RD 20 0 00c0ffee
SOC_RD 20 0 00c0ffee
SOC_RD 3f 0 cafe003f
UC_WR 21 13572468 0
CONTEND 08 0 0
CONTEND 0a 0 0
CONTEND 3f 0 0
UC_RD 00 0 cafe0000
SOC_RD 21 0 13572468

// File: verif/mbox_tb.sv
// **********************************************************************
// plays verif/mbox_cases.txt from the project root; mailbox reads must
// only touch words that an earlier case line wrote
// **********************************************************************
`default_nettype none

module mbox_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mbox_pkg::*;

    // a blocked uC request is watched this long for a stray grant
    localparam int BLOCK_CYCLES = 8;
    // longest wait for a grant on an uncontended request
    localparam int GNT_LIMIT = 16;
    localparam logic [15:0] LFSR_SEED = 16'd18775;

    logic       clk;
    logic       arst_n;
    logic       pwrgood;
    logic       ready_for_fuses;
    logic       uc_rst_b;
    logic       fuse_wr;
    fuse_addr_t fuse_addr;
    mbox_data_t fuse_wdata;
    fuse_addr_t uc_fuse_addr;
    mbox_data_t uc_fuse_rdata;
    logic       soc_req;
    logic       soc_we;
    mbox_addr_t soc_addr;
    mbox_data_t soc_wdata;
    logic       soc_gnt;
    mbox_data_t soc_rdata;
    logic       uc_req;
    logic       uc_we;
    mbox_addr_t uc_addr;
    mbox_data_t uc_wdata;
    logic       uc_gnt;
    mbox_data_t uc_rdata;

    // reference model of the mailbox, the fuse bank and the arbiter
    mbox_data_t  ref_mem [MBOX_DEPTH];
    mbox_data_t  ref_fuse [FUSE_WORDS];
    logic        fuse_open;
    logic        uc_released;
    logic        last_soc;
    logic [15:0] lfsr_q;

    // case lines as read from the file
    string       op_q [$];
    logic [31:0] addr_q [$];
    logic [31:0] data_q [$];
    logic [31:0] exp_q [$];
    int          n_cases = 0;

    mbox_top DUT (
        .clk             (clk),
        .arst_n          (arst_n),
        .pwrgood         (pwrgood),
        .ready_for_fuses (ready_for_fuses),
        .uc_rst_b        (uc_rst_b),
        .fuse_wr         (fuse_wr),
        .fuse_addr       (fuse_addr),
        .fuse_wdata      (fuse_wdata),
        .uc_fuse_addr    (uc_fuse_addr),
        .uc_fuse_rdata   (uc_fuse_rdata),
        .soc_req         (soc_req),
        .soc_we          (soc_we),
        .soc_addr        (soc_addr),
        .soc_wdata       (soc_wdata),
        .soc_gnt         (soc_gnt),
        .soc_rdata       (soc_rdata),
        .uc_req          (uc_req),
        .uc_we           (uc_we),
        .uc_addr         (uc_addr),
        .uc_wdata        (uc_wdata),
        .uc_gnt          (uc_gnt),
        .uc_rdata        (uc_rdata)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input mbox_data_t got, input mbox_data_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // the case file and the model have to agree before the DUT is judged
    task automatic check_case_expect(input int idx, input mbox_data_t file_exp,
                                     input mbox_data_t model_exp);
        if (file_exp !== model_exp) begin
            stop_on_error($sformatf("case %0d expects 0x%h but the model predicts 0x%h",
                                    idx, file_exp, model_exp));
        end
    endtask

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one LFSR step for every bit of the word
    task automatic next_random_word(output mbox_data_t w);
        w = '0;
        for (int i = 0; i < DATA_W; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w = {w[DATA_W-2:0], lfsr_q[0]};
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic advance_cycle();
        @(posedge clk);
        #1;
    endtask

    // side 0 is the SoC port, side 1 the uC port
    task automatic drive_side(input logic side, input logic req, input logic we,
                              input mbox_addr_t addr, input mbox_data_t wdata);
        if (side) begin
            uc_req   = req;
            uc_we    = we;
            uc_addr  = addr;
            uc_wdata = wdata;
        end else begin
            soc_req   = req;
            soc_we    = we;
            soc_addr  = addr;
            soc_wdata = wdata;
        end
    endtask

    // one uncontended access, held until its grant shows up
    task automatic access(input logic side, input logic we, input mbox_addr_t addr,
                          input mbox_data_t wdata);
        int    waited;
        logic  got;
        string name;
        waited = 0;
        got = 1'b0;
        name = side ? "uc_rdata" : "soc_rdata";
        drive_side(side, 1'b1, we, addr, wdata);
        while (!got) begin
            @(negedge clk);
            got = side ? uc_gnt : soc_gnt;
            if (!got) begin
                waited++;
                if (waited > GNT_LIMIT) begin
                    stop_on_error($sformatf("%s request got no grant in %0d cycles",
                                            side ? "uC" : "SoC", GNT_LIMIT));
                end
                advance_cycle();
            end
        end
        advance_cycle();
        drive_side(side, 1'b0, 1'b0, '0, '0);
        last_soc = !side;
        if (we) begin
            ref_mem[addr] = wdata;
        end else begin
            // read data belongs to the cycle right after the grant
            @(negedge clk);
            check_word(name, side ? uc_rdata : soc_rdata, ref_mem[addr]);
            advance_cycle();
        end
    endtask

    // a uC still held in reset must never be granted
    task automatic blocked_uc(input logic we, input mbox_addr_t addr, input mbox_data_t wdata);
        drive_side(1'b1, 1'b1, we, addr, wdata);
        repeat (BLOCK_CYCLES) begin
            @(negedge clk);
            check_bit("uc_gnt", uc_gnt, 1'b0);
            check_bit("uc_rst_b", uc_rst_b, 1'b0);
            advance_cycle();
        end
        drive_side(1'b1, 1'b0, 1'b0, '0, '0);
    endtask

    // both sides request in the same cycle, the loser follows one cycle later
    task automatic contend(input logic we, input mbox_addr_t a_soc, input mbox_addr_t a_uc,
                           input mbox_data_t d_soc, input mbox_data_t d_uc);
        logic soc_first;
        soc_first = !last_soc;
        drive_side(1'b0, 1'b1, we, a_soc, d_soc);
        drive_side(1'b1, 1'b1, we, a_uc, d_uc);
        @(negedge clk);
        check_bit("soc_gnt", soc_gnt, soc_first);
        check_bit("uc_gnt", uc_gnt, !soc_first);
        advance_cycle();
        drive_side(!soc_first, 1'b0, 1'b0, '0, '0);
        @(negedge clk);
        check_bit("soc_gnt", soc_gnt, !soc_first);
        check_bit("uc_gnt", uc_gnt, soc_first);
        if (!we && soc_first) begin
            check_word("soc_rdata", soc_rdata, ref_mem[a_soc]);
        end else if (!we) begin
            check_word("uc_rdata", uc_rdata, ref_mem[a_uc]);
        end
        advance_cycle();
        drive_side(soc_first, 1'b0, 1'b0, '0, '0);
        if (!we) begin
            @(negedge clk);
            // the first reader keeps its word while the second one arrives
            check_word("uc_rdata", uc_rdata, ref_mem[a_uc]);
            check_word("soc_rdata", soc_rdata, ref_mem[a_soc]);
            advance_cycle();
        end else begin
            ref_mem[a_soc] = d_soc;
            ref_mem[a_uc] = d_uc;
        end
        // the loser took the last grant
        last_soc = !soc_first;
    endtask

    // a done write is followed edge by edge until the uC leaves reset
    task automatic fuse_write(input fuse_addr_t addr, input mbox_data_t data);
        logic is_done;
        is_done = fuse_open && (addr == FUSE_DONE_ADDR);
        fuse_wr = 1'b1;
        fuse_addr = addr;
        fuse_wdata = data;
        advance_cycle();
        fuse_wr = 1'b0;
        if (fuse_open && addr < FUSE_WORDS) begin
            ref_fuse[addr[FUSE_IDX_W-1:0]] = data;
        end
        if (is_done) begin
            for (int k = 1; k <= 4; k++) begin
                check_bit("ready_for_fuses", ready_for_fuses, k < 2);
                check_bit("uc_rst_b", uc_rst_b, k >= 4);
                if (k < 4) begin
                    advance_cycle();
                end
            end
            fuse_open = 1'b0;
            uc_released = 1'b1;
        end
    endtask

    task automatic fuse_read(input int idx, input fuse_addr_t addr, input mbox_data_t exp);
        mbox_data_t model;
        model = (addr < FUSE_WORDS) ? ref_fuse[addr[FUSE_IDX_W-1:0]] : '0;
        check_case_expect(idx, exp, model);
        uc_fuse_addr = addr;
        @(negedge clk);
        check_word("uc_fuse_rdata", uc_fuse_rdata, model);
        advance_cycle();
    endtask

    // watchdog sized from the number of case lines
    initial begin
        wait (n_cases > 0);
        repeat (n_cases * 20 + 100) @(posedge clk);
        stop_on_error($sformatf("watchdog timeout after %0d cycles", n_cases * 20 + 100));
    end

    initial begin
        int          fd;
        int          code;
        int          ch;
        string       op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        mbox_addr_t  ma;
        mbox_addr_t  mb;
        mbox_data_t  w_soc;
        mbox_data_t  w_uc;
        arst_n = 1'b0;
        pwrgood = 1'b0;
        fuse_wr = 1'b0;
        fuse_addr = '0;
        fuse_wdata = '0;
        uc_fuse_addr = '0;
        drive_side(1'b0, 1'b0, 1'b0, '0, '0);
        drive_side(1'b1, 1'b0, 1'b0, '0, '0);
        lfsr_q = LFSR_SEED;
        fuse_open = 1'b0;
        uc_released = 1'b0;
        last_soc = 1'b0;
        for (int i = 0; i < MBOX_DEPTH; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < FUSE_WORDS; i++) begin
            ref_fuse[i] = '0;
        end

        fd = $fopen("verif/mbox_cases.txt", "r");
        if (fd == 0) begin
            stop_on_error("cannot open verif/mbox_cases.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
                break;
            end
            // comment lines are skipped up to their newline
            if (op.len() > 0 && op[0] == "#") begin
                ch = $fgetc(fd);
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
                continue;
            end
            code = $fscanf(fd, "%h %h %h", a, d, e);
            if (code != 3) begin
                stop_on_error({"malformed case line for opcode ", op});
            end
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            exp_q.push_back(e);
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            stop_on_error("the case file holds no operations");
        end
        n_cases = op_q.size();

        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_bit("ready_for_fuses", ready_for_fuses, 1'b0);
        check_bit("uc_rst_b", uc_rst_b, 1'b0);
        check_bit("soc_gnt", soc_gnt, 1'b0);
        check_bit("uc_gnt", uc_gnt, 1'b0);
        advance_cycle();

        foreach (op_q[i]) begin
            a = addr_q[i];
            d = data_q[i];
            e = exp_q[i];
            ma = a[MBOX_ADDR_W-1:0];
            if (!uc_released) begin
                check_bit("uc_rst_b", uc_rst_b, 1'b0);
            end
            if (op_q[i] == "PWRGOOD") begin
                if (e[0] !== 1'b1) begin
                    stop_on_error($sformatf("case %0d expects no fuse phase after PWRGOOD", i));
                end
                pwrgood = 1'b1;
                check_bit("ready_for_fuses", ready_for_fuses, 1'b0);
                advance_cycle();
                check_bit("ready_for_fuses", ready_for_fuses, 1'b1);
                fuse_open = 1'b1;
            end else if (op_q[i] == "FUSE_WR") begin
                fuse_write(a[FUSE_ADDR_W-1:0], d);
            end else if (op_q[i] == "FUSE_RD") begin
                fuse_read(i, a[FUSE_ADDR_W-1:0], e);
            end else if (op_q[i] == "SOC_WR") begin
                access(1'b0, 1'b1, ma, d);
            end else if (op_q[i] == "SOC_RD") begin
                check_case_expect(i, e, ref_mem[ma]);
                access(1'b0, 1'b0, ma, '0);
            end else if (op_q[i] == "UC_WR" || op_q[i] == "UC_RD") begin
                if (!uc_released) begin
                    blocked_uc(op_q[i] == "UC_WR", ma, d);
                end else if (op_q[i] == "UC_WR") begin
                    access(1'b1, 1'b1, ma, d);
                end else begin
                    check_case_expect(i, e, ref_mem[ma]);
                    access(1'b1, 1'b0, ma, '0);
                end
            end else if (op_q[i] == "CONTEND") begin
                if (!uc_released) begin
                    stop_on_error($sformatf("case %0d contends before the uC is released", i));
                end
                // the partner word is the even/odd neighbour, so no address wraps
                mb = ma ^ 6'd1;
                next_random_word(w_soc);
                next_random_word(w_uc);
                contend(1'b1, ma, mb, w_soc, w_uc);
                // each side reads back the word the other one wrote
                contend(1'b0, mb, ma, '0, '0);
            end else begin
                stop_on_error({"unknown opcode in case file: ", op_q[i]});
            end
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule : mbox_tb

`default_nettype wire
